// ==== hdl/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    ////////////////////////////////////////////////////////////
    // geometry
    ////////////////////////////////////////////////////////////
    localparam int ADDR_W   = 32;
    localparam int WORD_W   = 64;
    localparam int LINE_W   = 256;
    localparam int BEATS    = LINE_W / WORD_W;
    localparam int OFFSET_W = 5;
    localparam int DEF_SETS = 64;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [WORD_W/8-1:0]   strb_t;
    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [LINE_W/8-1:0]   line_be_t;

    ////////////////////////////////////////////////////////////
    // channel payloads
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        strb_t strb;
    } cpu_req_t;

    // shared by AR and AW
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } addr_ch_t;

    // shared by R and W
    typedef struct packed {
        logic  valid;
        word_t data;
        logic  last;
    } beat_t;

    typedef struct packed {
        logic     en;
        logic     way;
        addr_t    addr;
        line_t    line;
        line_be_t be;
    } line_wr_t;

    typedef enum logic [1:0] {
        TAG_NONE,
        TAG_FILL,
        TAG_SET_DIRTY,
        TAG_CLEAN
    } tag_upd_kind_e;

    typedef struct packed {
        tag_upd_kind_e kind;
        logic          way;
        addr_t         addr;
    } tag_upd_t;

endpackage

`default_nettype wire

// ==== hdl/tag_store.sv ====
`default_nettype none
`timescale 1ns/10ps

module tag_store #(
    parameter int SETS = dcache_pkg::DEF_SETS
) (
    input  wire logic                 I_clk,
    input  wire logic                 I_rst,
    input  wire dcache_pkg::addr_t    lookup_addr,
    input  wire dcache_pkg::tag_upd_t tag_upd,
    output logic                      hit,
    output logic                      hit_way,
    output logic                      victim_way,
    output logic                      victim_dirty,
    output dcache_pkg::addr_t         victim_tag
);

    import dcache_pkg::*;

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = ADDR_W - IDX_W - OFFSET_W;

    logic [TAG_W-1:0] tag_q [SETS][2];
    logic [1:0]       valid_q [SETS];
    logic [1:0]       dirty_q [SETS];

    logic [IDX_W-1:0] lk_idx;
    logic [TAG_W-1:0] lk_tag;
    logic [IDX_W-1:0] up_idx;
    logic [TAG_W-1:0] up_tag;
    logic [1:0]       way_hit;

    assign lk_idx = lookup_addr[OFFSET_W +: IDX_W];
    assign lk_tag = lookup_addr[ADDR_W-1 -: TAG_W];
    assign up_idx = tag_upd.addr[OFFSET_W +: IDX_W];
    assign up_tag = tag_upd.addr[ADDR_W-1 -: TAG_W];

    ////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////
    assign way_hit[0] = valid_q[lk_idx][0] && (tag_q[lk_idx][0] == lk_tag);
    assign way_hit[1] = valid_q[lk_idx][1] && (tag_q[lk_idx][1] == lk_tag);
    assign hit        = |way_hit;
    assign hit_way    = way_hit[1];

    // way 1 on its hit, or on a miss filling an empty way 1 next to a valid way 0
    assign victim_way   = way_hit[1] || (!hit && valid_q[lk_idx][0] && !valid_q[lk_idx][1]);
    assign victim_dirty = dirty_q[lk_idx][victim_way];
    assign victim_tag   = {tag_q[lk_idx][victim_way], {(ADDR_W - TAG_W){1'b0}}};

    ////////////////////////////////////////////////////////////
    // updates
    ////////////////////////////////////////////////////////////
    always_ff @(posedge I_clk) begin
        if (tag_upd.kind == TAG_FILL) begin
            tag_q[up_idx][tag_upd.way] <= up_tag;
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            case (tag_upd.kind)
                TAG_FILL:      valid_q[up_idx][tag_upd.way] <= 1'b1;
                TAG_SET_DIRTY: dirty_q[up_idx][tag_upd.way] <= 1'b1;
                TAG_CLEAN:     dirty_q[up_idx][tag_upd.way] <= 1'b0;
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/line_store.sv ====
`default_nettype none
`timescale 1ns/10ps

module line_store #(
    parameter int SETS = dcache_pkg::DEF_SETS
) (
    input  wire logic                 I_clk,
    input  wire logic                 rd_strobe,
    input  wire dcache_pkg::addr_t    rd_addr,
    output dcache_pkg::line_t         way_lines [2],
    input  wire dcache_pkg::line_wr_t line_wr
);

    import dcache_pkg::*;

    localparam int IDX_W = $clog2(SETS);

    line_t            data_q [SETS][2];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    assign rd_idx = rd_addr[OFFSET_W +: IDX_W];
    assign wr_idx = line_wr.addr[OFFSET_W +: IDX_W];

    // byte-enabled write into one way
    always_ff @(posedge I_clk) begin
        if (line_wr.en) begin
            for (int b = 0; b < LINE_W / 8; b++) begin
                if (line_wr.be[b]) begin
                    data_q[wr_idx][line_wr.way][b * 8 +: 8] <= line_wr.line[b * 8 +: 8];
                end
            end
        end
    end

    // both ways read together, held until the next strobe
    always_ff @(posedge I_clk) begin
        if (rd_strobe) begin
            for (int w = 0; w < 2; w++) begin
                way_lines[w] <= data_q[rd_idx][w];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mem_port.sv ====
`default_nettype none
`timescale 1ns/10ps

module mem_port (
    input  wire logic              I_clk,
    input  wire logic              I_rst,
    input  wire logic              refill_start,
    input  wire logic              wb_start,
    input  wire dcache_pkg::addr_t line_addr,
    input  wire dcache_pkg::addr_t wb_addr,
    input  wire dcache_pkg::line_t wb_line,
    output dcache_pkg::line_t      refill_line,
    output logic                   refill_done,
    output logic                   wb_done,
    output dcache_pkg::addr_ch_t   mem_ar,
    input  wire logic              mem_arready,
    input  wire dcache_pkg::beat_t mem_r,
    output dcache_pkg::addr_ch_t   mem_aw,
    input  wire logic              mem_awready,
    output dcache_pkg::beat_t      mem_w,
    input  wire logic              mem_wready,
    input  wire logic              mem_bvalid
);

    import dcache_pkg::*;

    localparam int CNT_W = $clog2(BEATS);

    addr_ch_t          ar_q;
    addr_ch_t          aw_q;
    line_t             rbuf_q;
    logic              w_active_q;
    logic              b_wait_q;
    logic [CNT_W-1:0]  beat_q;
    logic              w_last;
    logic              w_fire;

    ////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            ar_q        <= '0;
            refill_done <= 1'b0;
        end else begin
            if (refill_start) begin
                ar_q.valid <= 1'b1;
                ar_q.addr  <= line_addr;
            end else if (mem_arready) begin
                ar_q.valid <= 1'b0;
            end
            refill_done <= mem_r.valid && mem_r.last;
        end
    end

    // first beat ends up in the low word after four shifts
    always_ff @(posedge I_clk) begin
        if (mem_r.valid) begin
            rbuf_q <= {mem_r.data, rbuf_q[LINE_W-1:WORD_W]};
        end
    end

    assign mem_ar      = ar_q;
    assign refill_line = rbuf_q;

    ////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////
    assign w_last = (beat_q == CNT_W'(BEATS - 1));
    assign w_fire = w_active_q && mem_wready;

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            aw_q       <= '0;
            w_active_q <= 1'b0;
            b_wait_q   <= 1'b0;
            beat_q     <= '0;
        end else begin
            if (wb_start) begin
                aw_q.valid <= 1'b1;
                aw_q.addr  <= wb_addr;
            end else if (mem_awready) begin
                aw_q.valid <= 1'b0;
            end
            // data beats only after the address is taken
            if (aw_q.valid && mem_awready) begin
                w_active_q <= 1'b1;
            end else if (w_fire && w_last) begin
                w_active_q <= 1'b0;
            end
            if (w_fire) begin
                beat_q <= beat_q + CNT_W'(1);
            end
            if (w_fire && w_last) begin
                b_wait_q <= 1'b1;
            end else if (mem_bvalid) begin
                b_wait_q <= 1'b0;
            end
        end
    end

    assign mem_aw     = aw_q;
    assign mem_w.valid = w_active_q;
    assign mem_w.data  = wb_line[beat_q * WORD_W +: WORD_W];
    assign mem_w.last  = w_active_q && w_last;
    assign wb_done     = b_wait_q && mem_bvalid;

endmodule

`default_nettype wire

// ==== hdl/dcache_ctrl.sv ====
`default_nettype none
`timescale 1ns/10ps

module dcache_ctrl #(
    parameter int SETS = dcache_pkg::DEF_SETS
) (
    input  wire logic                 I_clk,
    input  wire logic                 I_rst,
    input  wire dcache_pkg::cpu_req_t cpu_req,
    input  wire logic                 cpu_rd,
    input  wire logic                 cpu_wr,
    output logic                      cpu_ready,
    output dcache_pkg::word_t         cpu_rdata,
    output logic                      cpu_rvalid,
    output logic                      cpu_bvalid,
    input  wire logic                 hit,
    input  wire logic                 hit_way,
    input  wire logic                 victim_way,
    input  wire logic                 victim_dirty,
    input  wire dcache_pkg::addr_t    victim_tag,
    output dcache_pkg::tag_upd_t      tag_upd,
    output logic                      rd_strobe,
    output dcache_pkg::line_wr_t      line_wr,
    input  wire dcache_pkg::line_t    way_lines [2],
    output logic                      refill_start,
    output logic                      wb_start,
    output dcache_pkg::addr_t         line_addr,
    output dcache_pkg::addr_t         wb_addr,
    output dcache_pkg::line_t         wb_line,
    input  wire dcache_pkg::line_t    refill_line,
    input  wire logic                 refill_done,
    input  wire logic                 wb_done
);

    import dcache_pkg::*;

    localparam int IDX_W  = $clog2(SETS);
    localparam int WSEL_W = $clog2(BEATS);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_HIT,
        S_WR_HIT,
        S_MISS,
        S_WB,
        S_ALLOC
    } state_e;

    state_e            state_q;
    state_e            state_d;
    cpu_req_t          req_q;
    logic              req_wr_q;
    logic              way_q;
    logic              vdirty_q;
    addr_t             vtag_q;
    logic              accept;
    logic              wr_hit;
    addr_t             cur_addr;
    logic [WSEL_W-1:0] hit_sel;
    logic [WSEL_W-1:0] req_sel;
    line_be_t          hit_be;
    line_t             merged_line;
    line_t             resp_line;

    assign cpu_ready = (state_q == S_IDLE) || (state_q == S_RD_HIT) || (state_q == S_WR_HIT);
    assign accept    = cpu_ready && (cpu_rd || cpu_wr);
    assign wr_hit    = accept && cpu_wr && hit;
    // live request while ready, latched one during a miss
    assign cur_addr  = cpu_ready ? cpu_req.addr : req_q.addr;
    assign hit_sel   = cpu_req.addr[OFFSET_W-1 -: WSEL_W];
    assign req_sel   = req_q.addr[OFFSET_W-1 -: WSEL_W];

    ////////////////////////////////////////////////////////////
    // request latch and state
    ////////////////////////////////////////////////////////////
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            state_q  <= S_IDLE;
            req_wr_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                req_wr_q <= cpu_wr;
            end
        end
    end

    // victim choice already equals the hit way on a hit
    always_ff @(posedge I_clk) begin
        if (accept) begin
            req_q    <= cpu_req;
            way_q    <= victim_way;
            vdirty_q <= victim_dirty;
            vtag_q   <= victim_tag;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE, S_RD_HIT, S_WR_HIT: begin
                if (!accept) begin
                    state_d = S_IDLE;
                end else if (!hit) begin
                    state_d = S_MISS;
                end else if (cpu_wr) begin
                    state_d = S_WR_HIT;
                end else begin
                    state_d = S_RD_HIT;
                end
            end
            S_MISS: begin
                if (refill_done) begin
                    state_d = vdirty_q ? S_WB : S_ALLOC;
                end
            end
            S_WB: begin
                if (wb_done) begin
                    state_d = S_ALLOC;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // tag and line updates
    ////////////////////////////////////////////////////////////
    always_comb begin
        tag_upd.kind = TAG_NONE;
        tag_upd.way  = cpu_ready ? hit_way : way_q;
        tag_upd.addr = cur_addr;
        if (wr_hit) begin
            tag_upd.kind = TAG_SET_DIRTY;
        end else if (state_q == S_MISS && refill_done && !vdirty_q && req_wr_q) begin
            tag_upd.kind = TAG_SET_DIRTY;
        end else if (state_q == S_WB && wb_done) begin
            // victim is now clean in memory, a write dirties it again
            tag_upd.kind = req_wr_q ? TAG_SET_DIRTY : TAG_CLEAN;
        end else if (state_q == S_ALLOC) begin
            tag_upd.kind = TAG_FILL;
        end
    end

    // write-miss merge of the cpu word into the refilled line
    always_comb begin
        merged_line = refill_line;
        if (req_wr_q) begin
            for (int i = 0; i < WORD_W / 8; i++) begin
                if (req_q.strb[i]) begin
                    merged_line[req_sel * WORD_W + i * 8 +: 8] = req_q.wdata[i * 8 +: 8];
                end
            end
        end
    end

    always_comb begin
        hit_be = '0;
        hit_be[hit_sel * (WORD_W / 8) +: WORD_W / 8] = cpu_req.strb;
        line_wr.way  = cpu_ready ? hit_way : way_q;
        line_wr.addr = cur_addr;
        if (state_q == S_ALLOC) begin
            line_wr.en   = 1'b1;
            line_wr.line = merged_line;
            line_wr.be   = '1;
        end else begin
            line_wr.en   = wr_hit;
            line_wr.line = {BEATS{cpu_req.wdata}};
            line_wr.be   = hit_be;
        end
    end

    ////////////////////////////////////////////////////////////
    // memory port and cpu response
    ////////////////////////////////////////////////////////////
    assign rd_strobe    = accept;
    assign refill_start = accept && !hit;
    assign line_addr    = {cur_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign wb_start     = (state_q == S_MISS) && refill_done && vdirty_q;
    assign wb_addr      = vtag_q | {{(ADDR_W - IDX_W - OFFSET_W){1'b0}},
                                    req_q.addr[OFFSET_W +: IDX_W], {OFFSET_W{1'b0}}};
    assign wb_line      = way_lines[way_q];

    assign resp_line  = (state_q == S_ALLOC) ? merged_line : way_lines[way_q];
    assign cpu_rdata  = resp_line[req_sel * WORD_W +: WORD_W];
    assign cpu_rvalid = (state_q == S_RD_HIT) || (state_q == S_ALLOC && !req_wr_q);
    assign cpu_bvalid = (state_q == S_WR_HIT) || (state_q == S_ALLOC && req_wr_q);

endmodule

`default_nettype wire

// ==== hdl/dcache_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module dcache_top #(
    parameter int SETS = dcache_pkg::DEF_SETS
) (
    input  wire logic                 I_clk,
    input  wire logic                 I_rst,
    // cpu side
    input  wire dcache_pkg::cpu_req_t cpu_req,
    input  wire logic                 cpu_rd,
    input  wire logic                 cpu_wr,
    output logic                      cpu_ready,
    output dcache_pkg::word_t         cpu_rdata,
    output logic                      cpu_rvalid,
    output logic                      cpu_bvalid,
    // memory side
    output dcache_pkg::addr_ch_t      mem_ar,
    input  wire logic                 mem_arready,
    input  wire dcache_pkg::beat_t    mem_r,
    output dcache_pkg::addr_ch_t      mem_aw,
    input  wire logic                 mem_awready,
    output dcache_pkg::beat_t         mem_w,
    input  wire logic                 mem_wready,
    input  wire logic                 mem_bvalid
);

    import dcache_pkg::*;

    // tag store results
    logic     hit;
    logic     hit_way;
    logic     victim_way;
    logic     victim_dirty;
    addr_t    victim_tag;
    tag_upd_t tag_upd;

    // line store
    logic     rd_strobe;
    line_wr_t line_wr;
    line_t    way_lines [2];

    // memory port handshake
    logic     refill_start;
    logic     wb_start;
    addr_t    line_addr;
    addr_t    wb_addr;
    line_t    wb_line;
    line_t    refill_line;
    logic     refill_done;
    logic     wb_done;

    dcache_ctrl #(.SETS(SETS)) u_ctrl (.*);

    tag_store #(.SETS(SETS)) u_tags (
        .lookup_addr (cpu_req.addr),
        .*
    );

    // lines are only read on acceptance, so the cpu address is the index
    line_store #(.SETS(SETS)) u_lines (
        .rd_addr (cpu_req.addr),
        .*
    );

    mem_port u_mem (.*);

endmodule

`default_nettype wire

// ==== sim/dcache_props.sv ====
`default_nettype none
`timescale 1ns/10ps

module dcache_props (
    input wire logic                 I_clk,
    input wire logic                 I_rst,
    input wire logic                 cpu_ready,
    input wire logic                 cpu_rvalid,
    input wire logic                 cpu_bvalid,
    input wire dcache_pkg::addr_ch_t mem_ar,
    input wire logic                 mem_arready,
    input wire dcache_pkg::addr_ch_t mem_aw,
    input wire logic                 mem_awready,
    input wire dcache_pkg::beat_t    mem_w,
    input wire logic                 mem_wready
);

    logic [1:0] w_beats_q;

    // W beats taken so far in the current burst
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            w_beats_q <= '0;
        end else if (mem_w.valid && mem_wready) begin
            w_beats_q <= w_beats_q + 2'd1;
        end
    end

    resp_exclusive: assert property (@(posedge I_clk) disable iff (I_rst)
        !(cpu_rvalid && cpu_bvalid))
        else $error("rvalid and bvalid high together");

    ar_hold: assert property (@(posedge I_clk) disable iff (I_rst)
        mem_ar.valid && !mem_arready |=> mem_ar.valid && $stable(mem_ar.addr))
        else $error("AR dropped or changed before ready");

    aw_hold: assert property (@(posedge I_clk) disable iff (I_rst)
        mem_aw.valid && !mem_awready |=> mem_aw.valid && $stable(mem_aw.addr))
        else $error("AW dropped or changed before ready");

    w_last_fourth: assert property (@(posedge I_clk) disable iff (I_rst)
        mem_w.valid && mem_wready |-> (mem_w.last == (w_beats_q == 2'd3)))
        else $error("W last not on the fourth beat");

    // cpu waits during a refill
    ready_during_ar: assert property (@(posedge I_clk) disable iff (I_rst)
        mem_ar.valid |-> !cpu_ready)
        else $error("cpu_ready high while AR valid");

endmodule

bind dcache_top dcache_props u_props (
    .I_clk       (I_clk),
    .I_rst       (I_rst),
    .cpu_ready   (cpu_ready),
    .cpu_rvalid  (cpu_rvalid),
    .cpu_bvalid  (cpu_bvalid),
    .mem_ar      (mem_ar),
    .mem_arready (mem_arready),
    .mem_aw      (mem_aw),
    .mem_awready (mem_awready),
    .mem_w       (mem_w),
    .mem_wready  (mem_wready)
);

`default_nettype wire

// ==== sim/dcache_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module dcache_tb;

    import dcache_pkg::*;

    // 400 transactions at up to 40 cycles each, plus margin
    localparam int MAX_CYCLES = 20000;
    localparam int RAND_OPS   = 400;
    localparam int IDX_W      = $clog2(DEF_SETS);

    logic     I_clk = 1'b0;
    logic     I_rst;
    cpu_req_t cpu_req;
    logic     cpu_rd;
    logic     cpu_wr;
    logic     cpu_ready;
    word_t    cpu_rdata;
    logic     cpu_rvalid;
    logic     cpu_bvalid;
    addr_ch_t mem_ar;
    logic     mem_arready = 1'b0;
    beat_t    mem_r = '0;
    addr_ch_t mem_aw;
    logic     mem_awready = 1'b0;
    beat_t    mem_w;
    logic     mem_wready = 1'b0;
    logic     mem_bvalid = 1'b0;

    // memory model and shadow, both indexed by word address
    word_t mem_words [addr_t];
    word_t shadow [addr_t];
    word_t exp_q [$];
    addr_t addr_q [$];

    int    errors = 0;
    int    checks = 0;
    int    cycles = 0;
    int    ar_count = 0;
    int    aw_count = 0;
    addr_t last_ar_addr;
    addr_t last_aw_addr;

    // memory model state
    int    ar_wait = -1;
    int    aw_wait = -1;
    logic  r_active = 1'b0;
    addr_t r_addr;
    int    r_beat;
    int    r_gap;
    addr_t w_addr;
    int    w_beat;

    dcache_top #(.SETS(DEF_SETS)) dcache_top_i (.*);

    always #10 I_clk = ~I_clk;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    // background contents of words never written
    function automatic word_t fill_word(input addr_t waddr);
        return {waddr ^ 32'hc3a5_0f1e, ~waddr};
    endfunction

    function automatic word_t mem_read(input addr_t waddr);
        if (mem_words.exists(waddr)) begin
            return mem_words[waddr];
        end
        return fill_word(waddr);
    endfunction

    // word the cpu must see at a byte address
    function automatic word_t expected_word(input addr_t addr);
        addr_t waddr;
        waddr = addr >> 3;
        if (shadow.exists(waddr)) begin
            return shadow[waddr];
        end
        return fill_word(waddr);
    endfunction

    task automatic shadow_write(input addr_t addr, input word_t data, input strb_t strb);
        word_t w;
        w = expected_word(addr);
        for (int i = 0; i < WORD_W / 8; i++) begin
            if (strb[i]) begin
                w[i * 8 +: 8] = data[i * 8 +: 8];
            end
        end
        shadow[addr >> 3] = w;
    endtask

    function automatic addr_t make_addr(input int tag, input int set, input int word);
        return addr_t'((tag << (IDX_W + OFFSET_W)) | (set << OFFSET_W) | (word << 3));
    endfunction

    task automatic end_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////
    // memory model
    ////////////////////////////////////////////////////////////
    // ready after a random wait of 0 to 3 cycles per address
    task automatic addr_ready(input logic valid, inout int wait_cnt, output logic ready);
        ready = 1'b0;
        if (valid === 1'b1) begin
            if (wait_cnt < 0) begin
                wait_cnt = $urandom % 4;
            end
            if (wait_cnt == 0) begin
                ready    = 1'b1;
                wait_cnt = -1;
            end else begin
                wait_cnt--;
            end
        end
    endtask

    always begin : memory_model
        logic  ar_hs;
        logic  aw_hs;
        logic  w_hs;
        addr_t ar_addr_s;
        addr_t aw_addr_s;
        beat_t w_s;
        addr_t waddr;
        word_t exp_word;
        // handshakes that complete at the coming edge
        @(negedge I_clk);
        ar_hs     = (mem_ar.valid && mem_arready) === 1'b1;
        aw_hs     = (mem_aw.valid && mem_awready) === 1'b1;
        w_hs      = (mem_w.valid && mem_wready) === 1'b1;
        ar_addr_s = mem_ar.addr;
        aw_addr_s = mem_aw.addr;
        w_s       = mem_w;
        @(posedge I_clk);
        #2;
        if (ar_hs) begin
            ar_count++;
            last_ar_addr = ar_addr_s;
            r_addr       = ar_addr_s >> 3;
            r_beat       = 0;
            r_gap        = $urandom % 3;
            r_active     = 1'b1;
        end
        if (aw_hs) begin
            aw_count++;
            last_aw_addr = aw_addr_s;
            w_addr       = aw_addr_s >> 3;
            w_beat       = 0;
        end
        mem_bvalid = 1'b0;
        if (w_hs) begin
            waddr    = w_addr + addr_t'(w_beat);
            exp_word = expected_word(waddr << 3);
            checks++;
            if (w_s.data !== exp_word) begin
                $display("** Error at %0t: W beat %0d at %h is %h, expected %h",
                         $time, w_beat, waddr << 3, w_s.data, exp_word);
                errors++;
            end
            if (w_s.last !== (w_beat == BEATS - 1)) begin
                $display("** Error at %0t: W last is %b on beat %0d", $time, w_s.last, w_beat);
                errors++;
            end
            mem_words[waddr] = w_s.data;
            w_beat++;
            mem_bvalid = w_s.last;
        end
        mem_r = '0;
        if (r_active) begin
            if (r_gap > 0) begin
                r_gap--;
            end else begin
                mem_r.valid = 1'b1;
                mem_r.data  = mem_read(r_addr + addr_t'(r_beat));
                mem_r.last  = (r_beat == BEATS - 1);
                r_beat++;
                r_active = (r_beat < BEATS);
                r_gap    = $urandom % 3;
            end
        end
        addr_ready(mem_ar.valid, ar_wait, mem_arready);
        addr_ready(mem_aw.valid, aw_wait, mem_awready);
        mem_wready = ($urandom % 3) != 0;
    end

    ////////////////////////////////////////////////////////////
    // cpu side
    ////////////////////////////////////////////////////////////
    task automatic cpu_access(input logic wr, input addr_t addr, input word_t wdata,
                              input strb_t strb, output int latency);
        @(posedge I_clk);
        #2;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        cpu_req.strb  = strb;
        cpu_rd        = !wr;
        cpu_wr        = wr;
        @(negedge I_clk);
        while (cpu_ready !== 1'b1) begin
            @(negedge I_clk);
        end
        // accepted at the coming edge
        if (wr) begin
            shadow_write(addr, wdata, strb);
        end else begin
            exp_q.push_back(expected_word(addr));
            addr_q.push_back(addr);
        end
        @(posedge I_clk);
        #2;
        cpu_rd  = 1'b0;
        cpu_wr  = 1'b0;
        latency = 0;
        do begin
            @(negedge I_clk);
            latency++;
        end while ((wr ? cpu_bvalid : cpu_rvalid) !== 1'b1);
    endtask

    // one access with the refill and write-back it must cause
    task automatic directed(input logic wr, input addr_t addr, input word_t wdata,
                            input strb_t strb, input logic exp_hit, input logic exp_wb,
                            input addr_t wb_line_addr);
        int lat;
        int ar_before;
        int aw_before;
        ar_before = ar_count;
        aw_before = aw_count;
        cpu_access(wr, addr, wdata, strb, lat);
        checks++;
        if (exp_hit && (lat != 1 || ar_count != ar_before)) begin
            $display("** Error at %0t: hit at %h took %0d cycles and %0d AR",
                     $time, addr, lat, ar_count - ar_before);
            errors++;
        end
        if (!exp_hit && (ar_count != ar_before + 1 || last_ar_addr != (addr & 32'hffff_ffe0))) begin
            $display("** Error at %0t: miss at %h gave %0d AR, last at %h",
                     $time, addr, ar_count - ar_before, last_ar_addr);
            errors++;
        end
        if (aw_count != aw_before + (exp_wb ? 1 : 0)) begin
            $display("** Error at %0t: access at %h gave %0d AW, expected %0d",
                     $time, addr, aw_count - aw_before, exp_wb ? 1 : 0);
            errors++;
        end else if (exp_wb && last_aw_addr != wb_line_addr) begin
            $display("** Error at %0t: write-back to %h, expected %h",
                     $time, last_aw_addr, wb_line_addr);
            errors++;
        end
    endtask

    // every read response against the value expected at acceptance
    always @(negedge I_clk) begin
        word_t exp_word;
        addr_t exp_addr;
        if (cpu_rvalid === 1'b1) begin
            checks++;
            if (exp_q.size() == 0) begin
                $display("read response at %0t with no read outstanding", $time);
                errors++;
            end else begin
                exp_word = exp_q.pop_front();
                exp_addr = addr_q.pop_front();
                if (cpu_rdata !== exp_word) begin
                    $display("** Error at %0t: read %h returned %h, expected %h",
                             $time, exp_addr, cpu_rdata, exp_word);
                    errors++;
                end
            end
        end
    end

    always @(posedge I_clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            errors++;
            end_run();
        end
    end

    initial begin
        int    lat;
        logic  wr;
        addr_t addr;
        void'($urandom(71));
        I_rst   = 1'b1;
        cpu_req = '0;
        cpu_rd  = 1'b0;
        cpu_wr  = 1'b0;
        repeat (8) @(posedge I_clk);
        #2;
        I_rst = 1'b0;
        @(negedge I_clk);
        checks++;
        if (cpu_ready !== 1'b1 || mem_ar.valid !== 1'b0 || mem_aw.valid !== 1'b0 ||
            mem_w.valid !== 1'b0 || cpu_rvalid !== 1'b0 || cpu_bvalid !== 1'b0) begin
            $display("** Error at %0t: outputs not idle after reset", $time);
            errors++;
        end

        // read miss, then a hit in the same line
        directed(1'b0, make_addr(16, 2, 1), '0, '0, 1'b0, 1'b0, '0);
        directed(1'b0, make_addr(16, 2, 3), '0, '0, 1'b1, 1'b0, '0);
        // partial writes on a hit and on a miss, each read back
        directed(1'b1, make_addr(16, 2, 1), 64'h1122_3344_5566_7788, 8'h34, 1'b1, 1'b0, '0);
        directed(1'b0, make_addr(16, 2, 1), '0, '0, 1'b1, 1'b0, '0);
        directed(1'b1, make_addr(17, 3, 2), 64'hdead_beef_0bad_f00d, 8'hc1, 1'b0, 1'b0, '0);
        directed(1'b0, make_addr(17, 3, 2), '0, '0, 1'b1, 1'b0, '0);

        // three lines in set 5, way 0 empty then way 1 empty then way 0 again
        directed(1'b1, make_addr(256, 5, 0), 64'h0123_4567_89ab_cdef, 8'hff, 1'b0, 1'b0, '0);
        directed(1'b1, make_addr(257, 5, 1), 64'hfedc_ba98_7654_3210, 8'h0f, 1'b0, 1'b0, '0);
        directed(1'b1, make_addr(258, 5, 2), 64'h0f0f_f0f0_3c3c_c3c3, 8'hf0, 1'b0, 1'b1,
                 make_addr(256, 5, 0));
        directed(1'b0, make_addr(256, 5, 0), '0, '0, 1'b0, 1'b1, make_addr(258, 5, 0));
        directed(1'b0, make_addr(257, 5, 1), '0, '0, 1'b1, 1'b0, '0);
        // victim in way 0 is clean now
        directed(1'b0, make_addr(258, 5, 2), '0, '0, 1'b0, 1'b0, '0);

        // random mix over 8 sets and 24 lines
        for (int n = 0; n < RAND_OPS; n++) begin
            wr   = ($urandom % 2) != 0;
            addr = make_addr(768 + $urandom % 3, $urandom % 8, $urandom % 4);
            cpu_access(wr, addr, {$urandom, $urandom}, strb_t'($urandom), lat);
        end

        repeat (4) @(negedge I_clk);
        checks++;
        if (exp_q.size() != 0) begin
            $display("%0d reads were never answered", exp_q.size());
            errors++;
        end
        end_run();
    end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/dcache_pkg.sv
hdl/tag_store.sv
hdl/line_store.sv
hdl/mem_port.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
sim/dcache_props.sv
sim/dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dcache testbench with Verilator, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb -f files.f -o dcache_sim \
    && ./obj_dir/dcache_sim > sim.log 2>&1 \
    || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
